/* compile.f */
sm_ctl_pkg.sv
mem_range_if.sv
mem_range_walker.sv
sm_lookup.sv
result_writer.sv
sm_cmd_fsm.sv
sm_ctl_top.sv
tb_sm_ctl.sv

/* tb_sm_ctl.sv */
`timescale 1ns/1ps

module tb_sm_ctl;

    localparam logic [15:0] PC_MASK     = 16'h0001;
    localparam logic [15:0] R15_MASK    = 16'h8000;
    localparam int          NUM_CMDS    = 40;
    localparam int          CMD_TIMEOUT = 200;

    logic                clk;
    logic                reset;
    logic                start;
    logic                cmd_disable;
    logic                cmd_id;
    logic                cmd_id_prev;
    logic [15:0]         pc;
    logic [15:0]         r15;
    logic [15:0]         sm_data;
    logic [15:0]         sm_prev_id;
    logic                sm_data_select_valid;
    logic                busy;
    sm_ctl_pkg::sm_req_t sm_request;
    logic [15:0]         sm_data_select;
    logic                sm_data_select_type;
    logic                mb_en;
    logic [1:0]          mb_wr;
    logic [15:0]         mab;
    logic [15:0]         data_out;
    logic                reg_write;
    logic [15:0]         dest_reg;
    logic [15:0]         reg_data_out;

    // module table, one entry per protected module
    logic [3:0][15:0] tbl_id;
    logic [3:0][15:0] code_lo;
    logic [3:0][15:0] code_hi;
    logic [3:0][15:0] data_lo;
    logic [3:0][15:0] data_hi;
    int               sel_idx;

    logic [15:0] wr_addr_q[$];
    logic [15:0] wr_data_q[$];
    logic [1:0]  wr_be_q[$];
    logic [15:0] exp_addr_q[$];

    integer seed;
    int     errors;
    int     checks;
    int     timeouts;
    int     cmds_run;

    sm_ctl_top uut (
        .clk                  (clk),
        .reset                (reset),
        .start                (start),
        .cmd_disable          (cmd_disable),
        .cmd_id               (cmd_id),
        .cmd_id_prev          (cmd_id_prev),
        .pc                   (pc),
        .r15                  (r15),
        .sm_data              (sm_data),
        .sm_prev_id           (sm_prev_id),
        .sm_data_select_valid (sm_data_select_valid),
        .busy                 (busy),
        .sm_request           (sm_request),
        .sm_data_select       (sm_data_select),
        .sm_data_select_type  (sm_data_select_type),
        .mb_en                (mb_en),
        .mb_wr                (mb_wr),
        .mab                  (mab),
        .data_out             (data_out),
        .reg_write            (reg_write),
        .dest_reg             (dest_reg),
        .reg_data_out         (reg_data_out)
    );

    always #5 clk = ~clk;

    // module m owns 0x2000*(m+1) up to 0x1000 bytes above it
    function automatic int owner(input logic [15:0] addr);
        if (addr[12] == 1'b0 && addr[15:13] >= 3'd1 && addr[15:13] <= 3'd4)
        begin
            owner = addr[15:13] - 1;
        end
        else
        begin
            owner = -1;
        end
    endfunction

    // empty, inverted or a few words long
    function automatic logic [15:0] pick_end(input logic [15:0] lo);
        int kind;
        kind = $random(seed) & 3;
        if (kind == 0)
        begin
            pick_end = lo;
        end
        else if (kind == 1)
        begin
            pick_end = lo - 16'd2 * (($random(seed) & 3) + 1);
        end
        else
        begin
            pick_end = lo + 16'd2 * (($random(seed) & 7) + 1);
        end
    endfunction

    function automatic logic [15:0] pick_address();
        logic [15:0] region;
        if (($random(seed) & 3) != 0)
        begin
            region = ($random(seed) & 3) + 1;
            pick_address = region * 16'h2000 + ($random(seed) & 16'h0ffe);
        end
        else
        begin
            pick_address = $random(seed);
        end
    endfunction

    // table answers within the same cycle
    always_comb
    begin
        sel_idx = owner(sm_data_select);
        sm_data_select_valid = (sel_idx >= 0);
        sm_data = 16'h0000;
        if (sel_idx >= 0)
        begin
            case (sm_request)
                sm_ctl_pkg::REQ_PUBSTART: sm_data = code_lo[sel_idx];
                sm_ctl_pkg::REQ_PUBEND:   sm_data = code_hi[sel_idx];
                sm_ctl_pkg::REQ_SECSTART: sm_data = data_lo[sel_idx];
                sm_ctl_pkg::REQ_SECEND:   sm_data = data_hi[sel_idx];
                sm_ctl_pkg::REQ_ID:       sm_data = tbl_id[sel_idx];
                default:                  sm_data = 16'h0000;
            endcase
        end
    end

    // memory write log
    always @(posedge clk)
    begin
        if (mb_en === 1'b1 && mb_wr != 2'b00)
        begin
            wr_addr_q.push_back(mab);
            wr_data_q.push_back(data_out);
            wr_be_q.push_back(mb_wr);
        end
    end

    task automatic random_table();
        logic [15:0] base;
        logic [15:0] lo;
        for (int m = 0; m < 4; m++)
        begin
            base = 16'h2000 * (m + 1);
            tbl_id[m] <= $random(seed);
            lo = base + 16'd2 * ($random(seed) & 31);
            code_lo[m] <= lo;
            code_hi[m] <= pick_end(lo);
            lo = base + 16'h0400 + 16'd2 * ($random(seed) & 31);
            data_lo[m] <= lo;
            data_hi[m] <= pick_end(lo);
        end
    endtask

    task automatic run_command(input int n);
        int          kind;
        int          hit;
        int          cycles;
        int          pulses;
        int          pulse_cycle;
        bit          extra_start;
        logic [15:0] new_pc;
        logic [15:0] new_r15;
        logic [15:0] new_prev;
        logic [15:0] a;
        logic [15:0] exp_dest;
        logic [15:0] exp_data;
        logic [15:0] got_dest;
        logic [15:0] got_data;
        kind = ($random(seed) & 32'hff) % 3;
        new_pc = pick_address();
        new_r15 = pick_address();
        new_prev = $random(seed);
        extra_start = $random(seed) & 1;

        @(posedge clk);
        random_table();
        start       <= 1'b1;
        cmd_disable <= (kind == 0);
        cmd_id      <= (kind == 1);
        cmd_id_prev <= (kind == 2);
        pc          <= new_pc;
        r15         <= new_r15;
        sm_prev_id  <= new_prev;

        // start is sampled here, a held start must be ignored
        @(posedge clk);
        start <= extra_start;

        exp_dest = R15_MASK;
        exp_data = 16'h0000;
        exp_addr_q.delete();
        if (kind == 2)
        begin
            exp_data = new_prev;
        end
        else
        begin
            hit = owner((kind == 0) ? new_pc : new_r15);
            if (hit >= 0 && kind == 1)
            begin
                exp_data = tbl_id[hit];
            end
            if (hit >= 0 && kind == 0)
            begin
                exp_dest = PC_MASK;
                exp_data = new_r15;
                for (a = code_lo[hit]; a < code_hi[hit]; a = a + 16'd2)
                begin
                    exp_addr_q.push_back(a);
                end
                for (a = data_lo[hit]; a < data_hi[hit]; a = a + 16'd2)
                begin
                    exp_addr_q.push_back(a);
                end
            end
        end

        cycles = 0;
        pulses = 0;
        pulse_cycle = -1;
        do
        begin
            @(posedge clk);
            cycles++;
            if (cycles == 1)
            begin
                start <= 1'b0;
            end
            if (reg_write)
            begin
                pulses++;
                pulse_cycle = cycles;
                got_dest = dest_reg;
                got_data = reg_data_out;
            end
            else if (pulse_cycle < 0 && !busy)
            begin
                errors++;
                $display("[ERROR] %0t: cmd %0d busy low before result", $time, n);
            end
        end
        while ((pulse_cycle < 0 || busy) && cycles < CMD_TIMEOUT);

        if (pulse_cycle < 0 || busy)
        begin
            timeouts++;
            $display("timeout: command %0d did not finish within %0d cycles", n, CMD_TIMEOUT);
        end
        else
        begin
            checks++;
            if (cycles - pulse_cycle > 2)
            begin
                errors++;
                $display("[ERROR] %0t: cmd %0d busy fell %0d cycles after reg_write",
                         $time, n, cycles - pulse_cycle);
            end
            repeat (3)
            begin
                @(posedge clk);
                if (busy || reg_write)
                begin
                    errors++;
                    $display("[ERROR] %0t: cmd %0d activity after completion", $time, n);
                end
            end
            if (pulses != 1 || got_dest !== exp_dest || got_data !== exp_data)
            begin
                errors++;
                $display("[ERROR] %0t: cmd %0d kind %0d pulses %0d dest %h/%h data %h/%h",
                         $time, n, kind, pulses, got_dest, exp_dest, got_data, exp_data);
            end
            if (sm_data_select_type !== 1'b0)
            begin
                errors++;
                $display("[ERROR] %0t: cmd %0d select type not by address", $time, n);
            end
            if (wr_addr_q.size() != exp_addr_q.size())
            begin
                errors++;
                $display("[ERROR] %0t: cmd %0d wrote %0d words, expected %0d",
                         $time, n, wr_addr_q.size(), exp_addr_q.size());
            end
            else
            begin
                foreach (exp_addr_q[i])
                begin
                    if (wr_addr_q[i] !== exp_addr_q[i] || wr_data_q[i] !== 16'h0000 ||
                        wr_be_q[i] !== 2'b11)
                    begin
                        errors++;
                        $display("[ERROR] %0t: cmd %0d write %0d at %h data %h be %b, expected %h",
                                 $time, n, i, wr_addr_q[i], wr_data_q[i], wr_be_q[i],
                                 exp_addr_q[i]);
                    end
                end
            end
        end
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_be_q.delete();
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        cmd_disable = 1'b0;
        cmd_id = 1'b0;
        cmd_id_prev = 1'b0;
        pc = 16'h0000;
        r15 = 16'h0000;
        sm_prev_id = 16'h0000;
        tbl_id = '0;
        code_lo = '0;
        code_hi = '0;
        data_lo = '0;
        data_hi = '0;
        seed = 29540;
        errors = 0;
        checks = 0;
        timeouts = 0;
        cmds_run = 0;

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        checks++;
        if (busy || reg_write || mb_en || mb_wr != 2'b00 ||
            sm_request != sm_ctl_pkg::REQ_NONE || dest_reg !== 16'h0000 ||
            reg_data_out !== 16'h0000)
        begin
            errors++;
            $display("[ERROR] %0t: outputs not idle after reset", $time);
        end

        while (cmds_run < NUM_CMDS && timeouts == 0)
        begin
            run_command(cmds_run);
            cmds_run++;
        end

        $display("commands %0d, checks %0d, errors %0d, timeouts %0d",
                 cmds_run, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* sm_ctl_top.sv */
`timescale 1ns/1ps

module sm_ctl_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                cmd_disable,
    input  logic                cmd_id,
    input  logic                cmd_id_prev,
    input  sm_ctl_pkg::word_t   pc,
    input  sm_ctl_pkg::word_t   r15,
    input  sm_ctl_pkg::word_t   sm_data,
    input  sm_ctl_pkg::word_t   sm_prev_id,
    input  logic                sm_data_select_valid,
    output logic                busy,
    output sm_ctl_pkg::sm_req_t sm_request,
    output sm_ctl_pkg::word_t   sm_data_select,
    output logic                sm_data_select_type,
    output logic                mb_en,
    output logic [1:0]          mb_wr,
    output sm_ctl_pkg::word_t   mab,
    output sm_ctl_pkg::word_t   data_out,
    output logic                reg_write,
    output sm_ctl_pkg::word_t   dest_reg,
    output sm_ctl_pkg::word_t   reg_data_out
);

    logic sm_valid;
    logic result_fail;
    logic result_success;

    mem_range_if range_bus ();

    sm_cmd_fsm u_cmd_fsm (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .cmd_disable    (cmd_disable),
        .cmd_id         (cmd_id),
        .cmd_id_prev    (cmd_id_prev),
        .sm_data        (sm_data),
        .sm_valid       (sm_valid),
        .range          (range_bus.ctl),
        .busy           (busy),
        .sm_request     (sm_request),
        .mb_en          (mb_en),
        .mb_wr          (mb_wr),
        .data_out       (data_out),
        .result_fail    (result_fail),
        .result_success (result_success)
    );

    mem_range_walker u_walker (
        .clk   (clk),
        .range (range_bus.walker)
    );

    // the walker address drives the memory bus directly
    assign mab = range_bus.addr;

    sm_lookup u_lookup (
        .clk                  (clk),
        .reset                (reset),
        .cmd_disable          (cmd_disable),
        .cmd_id               (cmd_id),
        .pc                   (pc),
        .r15                  (r15),
        .sm_data_select_valid (sm_data_select_valid),
        .sm_data_select       (sm_data_select),
        .sm_data_select_type  (sm_data_select_type),
        .sm_valid             (sm_valid)
    );

    result_writer u_result (
        .clk            (clk),
        .reset          (reset),
        .result_fail    (result_fail),
        .result_success (result_success),
        .cmd_disable    (cmd_disable),
        .cmd_id_prev    (cmd_id_prev),
        .r15            (r15),
        .sm_data        (sm_data),
        .sm_prev_id     (sm_prev_id),
        .reg_write      (reg_write),
        .dest_reg       (dest_reg),
        .reg_data_out   (reg_data_out)
    );

endmodule

/* sm_cmd_fsm.sv */
`timescale 1ns/1ps

module sm_cmd_fsm (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic                cmd_disable,
    input  logic                cmd_id,
    input  logic                cmd_id_prev,
    input  sm_ctl_pkg::word_t   sm_data,
    input  logic                sm_valid,
    mem_range_if.ctl            range,
    output logic                busy,
    output sm_ctl_pkg::sm_req_t sm_request,
    output logic                mb_en,
    output logic [1:0]          mb_wr,
    output sm_ctl_pkg::word_t   data_out,
    output logic                result_fail,
    output logic                result_success
);

    sm_ctl_pkg::fsm_state_t state;
    sm_ctl_pkg::fsm_state_t next_state;

    always_comb
    begin
        case (state)
            sm_ctl_pkg::IDLE:
                next_state = start ? sm_ctl_pkg::CHECK_SM : sm_ctl_pkg::IDLE;
            sm_ctl_pkg::CHECK_SM:
                next_state = !sm_valid                ? sm_ctl_pkg::FAIL            :
                             cmd_disable              ? sm_ctl_pkg::CODE_INIT_START :
                             (cmd_id || cmd_id_prev)  ? sm_ctl_pkg::SUCCESS         :
                                                        sm_ctl_pkg::FAIL;
            sm_ctl_pkg::CODE_INIT_START:
                next_state = sm_ctl_pkg::CODE_INIT_END;
            sm_ctl_pkg::CODE_INIT_END:
                next_state = sm_ctl_pkg::CLEAR_CODE;
            sm_ctl_pkg::CLEAR_CODE:
                next_state = range.done ? sm_ctl_pkg::DATA_INIT_START : sm_ctl_pkg::CLEAR_CODE;
            sm_ctl_pkg::DATA_INIT_START:
                next_state = sm_ctl_pkg::DATA_INIT_END;
            sm_ctl_pkg::DATA_INIT_END:
                next_state = sm_ctl_pkg::CLEAR_DATA;
            sm_ctl_pkg::CLEAR_DATA:
                next_state = range.done ? sm_ctl_pkg::SUCCESS : sm_ctl_pkg::CLEAR_DATA;
            sm_ctl_pkg::SUCCESS:
                next_state = cmd_disable ? sm_ctl_pkg::WAIT : sm_ctl_pkg::IDLE;
            default:
                next_state = sm_ctl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= sm_ctl_pkg::IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    // range bounds come straight from the module table
    assign range.base  = sm_data;
    assign range.limit = sm_data;

    always_comb
    begin
        busy             = 1'b1;
        sm_request       = sm_ctl_pkg::REQ_NONE;
        mb_en            = 1'b0;
        mb_wr            = 2'b00;
        data_out         = '0;
        result_fail      = 1'b0;
        result_success   = 1'b0;
        range.base_load  = 1'b0;
        range.limit_load = 1'b0;
        range.step       = 1'b0;

        case (state)
            sm_ctl_pkg::IDLE:
            begin
                busy = 1'b0;
            end
            sm_ctl_pkg::CODE_INIT_START:
            begin
                sm_request      = sm_ctl_pkg::REQ_PUBSTART;
                range.base_load = 1'b1;
            end
            sm_ctl_pkg::CODE_INIT_END:
            begin
                sm_request       = sm_ctl_pkg::REQ_PUBEND;
                range.limit_load = 1'b1;
            end
            sm_ctl_pkg::DATA_INIT_START:
            begin
                sm_request      = sm_ctl_pkg::REQ_SECSTART;
                range.base_load = 1'b1;
            end
            sm_ctl_pkg::DATA_INIT_END:
            begin
                sm_request       = sm_ctl_pkg::REQ_SECEND;
                range.limit_load = 1'b1;
            end
            sm_ctl_pkg::CLEAR_CODE, sm_ctl_pkg::CLEAR_DATA:
            begin
                // one full word per cycle until the limit is reached
                if (!range.done)
                begin
                    mb_en      = 1'b1;
                    mb_wr      = 2'b11;
                    data_out   = sm_ctl_pkg::CLEAR_WORD;
                    range.step = 1'b1;
                end
            end
            sm_ctl_pkg::FAIL:
            begin
                result_fail = 1'b1;
            end
            sm_ctl_pkg::SUCCESS:
            begin
                sm_request     = sm_ctl_pkg::REQ_ID;
                result_success = 1'b1;
            end
            default:
            begin
            end
        endcase
    end

    // CHECK_SM decodes exactly one command
    one_cmd_at_start: assert property (
        @(posedge clk) disable iff (reset)
            (state == sm_ctl_pkg::IDLE && start) |->
                $onehot({cmd_disable, cmd_id, cmd_id_prev})
    );

endmodule

/* result_writer.sv */
`timescale 1ns/1ps

module result_writer (
    input  logic              clk,
    input  logic              reset,
    input  logic              result_fail,
    input  logic              result_success,
    input  logic              cmd_disable,
    input  logic              cmd_id_prev,
    input  sm_ctl_pkg::word_t r15,
    input  sm_ctl_pkg::word_t sm_data,
    input  sm_ctl_pkg::word_t sm_prev_id,
    output logic              reg_write,
    output sm_ctl_pkg::word_t dest_reg,
    output sm_ctl_pkg::word_t reg_data_out
);

    sm_ctl_pkg::word_t dest_val;
    sm_ctl_pkg::word_t result_val;

    // disable hands control back through pc, keeping r15
    assign dest_val = (result_success && cmd_disable) ? sm_ctl_pkg::DEST_PC
                                                      : sm_ctl_pkg::DEST_R15;

    // sm_data carries the module id while the FSM is in SUCCESS
    assign result_val = result_fail ? '0         :
                        cmd_disable ? r15        :
                        cmd_id_prev ? sm_prev_id : sm_data;

    always_ff @(posedge clk)
    begin
        if (reset || !(result_fail || result_success))
        begin
            reg_write    <= 1'b0;
            dest_reg     <= '0;
            reg_data_out <= '0;
        end
        else
        begin
            reg_write    <= 1'b1;
            dest_reg     <= dest_val;
            reg_data_out <= result_val;
        end
    end

    // every command ends in exactly one register write
    single_write_pulse: assert property (
        @(posedge clk) disable iff (reset) reg_write |=> !reg_write
    );

endmodule

/* sm_lookup.sv */
`timescale 1ns/1ps

module sm_lookup (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_disable,
    input  logic              cmd_id,
    input  sm_ctl_pkg::word_t pc,
    input  sm_ctl_pkg::word_t r15,
    input  logic              sm_data_select_valid,
    output sm_ctl_pkg::word_t sm_data_select,
    output logic              sm_data_select_type,
    output logic              sm_valid
);

    logic lookup_needed;

    // id asks about the module at r15, disable about the caller at pc
    assign sm_data_select      = cmd_id ? r15 : pc;
    assign sm_data_select_type = sm_ctl_pkg::SEL_BY_ADDR;

    assign lookup_needed = cmd_id | cmd_disable;

    // id_prev needs no table hit
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sm_valid <= 1'b0;
        end
        else
        begin
            sm_valid <= !lookup_needed | sm_data_select_valid;
        end
    end

endmodule

/* mem_range_walker.sv */
`timescale 1ns/1ps

module mem_range_walker (
    input logic         clk,
    mem_range_if.walker range
);

    sm_ctl_pkg::word_t addr_q;
    sm_ctl_pkg::word_t limit_q;

    // word address counter
    always_ff @(posedge clk)
    begin
        if (range.base_load)
        begin
            addr_q <= range.base;
        end
        else if (range.step)
        begin
            addr_q <= addr_q + sm_ctl_pkg::ADDR_STEP;
        end
    end

    always_ff @(posedge clk)
    begin
        if (range.limit_load)
        begin
            limit_q <= range.limit;
        end
    end

    assign range.addr = addr_q;

    // unsigned, so an inverted range is done at once
    assign range.done = (addr_q >= limit_q);

    // a step during a load would lose either the new base or the limit
    load_step_exclusive: assert property (
        @(posedge clk) not (range.step && (range.base_load || range.limit_load))
    );

endmodule

/* mem_range_if.sv */
`timescale 1ns/1ps

interface mem_range_if;

    // range setup from the sequencer
    sm_ctl_pkg::word_t base;
    sm_ctl_pkg::word_t limit;
    logic              base_load;
    logic              limit_load;
    logic              step;

    // walker state
    sm_ctl_pkg::word_t addr;
    logic              done;

    modport ctl (
        output base,
        output limit,
        output base_load,
        output limit_load,
        output step,
        input  addr,
        input  done
    );

    modport walker (
        input  base,
        input  limit,
        input  base_load,
        input  limit_load,
        input  step,
        output addr,
        output done
    );

endinterface

/* sm_ctl_pkg.sv */
package sm_ctl_pkg;

    // one processor word
    typedef logic [15:0] word_t;

    // word addresses advance in bytes
    localparam word_t ADDR_STEP = 16'd2;

    // what the module table puts on sm_data
    typedef enum logic [2:0] {
        REQ_NONE     = 3'd0,
        REQ_PUBSTART = 3'd1,
        REQ_PUBEND   = 3'd2,
        REQ_SECSTART = 3'd3,
        REQ_SECEND   = 3'd4,
        REQ_ID       = 3'd5
    } sm_req_t;

    // sm_data_select_type encoding
    localparam logic SEL_BY_ADDR = 1'b0;
    localparam logic SEL_BY_ID   = 1'b1;

    // one-hot register file masks
    localparam word_t DEST_R15 = 16'h8000;
    localparam word_t DEST_PC  = 16'h0001;

    // written to every word of a cleared range
    localparam word_t CLEAR_WORD = 16'h0000;

    typedef enum logic [3:0] {
        IDLE            = 4'd0,
        CHECK_SM        = 4'd1,
        CODE_INIT_START = 4'd2,
        CODE_INIT_END   = 4'd3,
        CLEAR_CODE      = 4'd4,
        DATA_INIT_START = 4'd5,
        DATA_INIT_END   = 4'd6,
        CLEAR_DATA      = 4'd7,
        FAIL            = 4'd8,
        SUCCESS         = 4'd9,
        WAIT            = 4'd10
    } fsm_state_t;

endpackage
